//--- bench/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;
	import fetch_pkg::*;

	localparam logic [31:0] PATTERN = 32'h5ac3_96e1;

	logic        clk;
	logic        nrst;
	logic        stall;
	pc_sel_e     pc_sel;
	logic [31:0] target;
	logic [31:0] instr;
	logic [31:0] instr_pc;
	logic        instr_val;
	logic        transducer_l15_val;
	logic [4:0]  transducer_l15_rqtype;
	logic [2:0]  transducer_l15_size;
	logic [31:0] transducer_l15_address;
	logic        transducer_l15_req_ack;
	logic        l15_transducer_header_ack;
	logic        l15_transducer_ack;
	logic        l15_transducer_val;
	logic [3:0]  l15_transducer_returntype;
	logic [63:0] l15_transducer_data_0;
	logic [63:0] l15_transducer_data_1;
	logic [31:0] exp_pc;  // next pc decode should see
	int          value_errs;
	int          other_errs;
	int          inv_seen;
	string       test_name;

	frontend_stage #(.RESET_VECTOR(RESET_VECTOR_DEFAULT)) frontend_stage_i (.*);
	l15_mem_model #(.PATTERN(PATTERN), .SEED(32'h039a_af5a)) l15_mem_model_i (.*);

	always #10 clk = ~clk;

	// pattern word of the pc with its bytes reversed
	function automatic logic [31:0] expected_instr(input logic [31:0] pc);
		logic [31:0] w;
		w = pc ^ PATTERN;
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
		value_errs++;
		$display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
	endtask

	task automatic other_error(input string what);
		other_errs++;
		$display("%s: %s", test_name, what);
	endtask

	task automatic wait_accept(input int limit);
		int n;
		n = 0;
		do
		begin
			@(posedge clk);
			n++;
		end
		while (!(transducer_l15_val && l15_transducer_header_ack) && n < limit);
		assert (transducer_l15_val && l15_transducer_header_ack)
			else other_error("no request was accepted in time");
		#2;
	endtask

	task automatic wait_deliveries(input int count);
		int got;
		int n;
		got = 0;
		n = 0;
		while (got < count && n < count * 40)
		begin
			@(posedge clk);
			n++;
			if (instr_val)
				got++;
		end
		assert (got == count) else other_error("instructions stopped arriving");
		#2;
	endtask

	// redirect while the accepted request is still out
	task automatic redirect_in_flight(input pc_sel_e sel, input logic [31:0] pc);
		wait_accept(100);
		pc_sel = sel;
		target = pc;
		exp_pc = (sel == sel_reset) ? RESET_VECTOR_DEFAULT : pc;
		@(posedge clk);
		#2;
		pc_sel = sel_seq;
	endtask

	always @(posedge clk)
	begin
		if (nrst && instr_val)
		begin
			assert (instr_pc == exp_pc) else value_error("pc", exp_pc, instr_pc);
			assert (instr == expected_instr(instr_pc))
				else value_error("instr", expected_instr(instr_pc), instr);
			exp_pc = exp_pc + 32'd4;
		end
		else if (nrst)
			assert (instr == NOP_INSTR) else value_error("idle instr", NOP_INSTR, instr);
	end

	// every request is a single-word instruction fill
	always @(posedge clk)
	begin
		if (nrst && transducer_l15_val)
		begin
			assert (transducer_l15_rqtype == RQ_IFILL)
				else value_error("rqtype", RQ_IFILL, transducer_l15_rqtype);
			assert (transducer_l15_size == RQ_SIZE_WORD)
				else value_error("size", RQ_SIZE_WORD, transducer_l15_size);
		end
	end

	// every return is taken in the cycle it is offered
	always @(posedge clk)
	begin
		if (nrst)
		begin
			if (l15_transducer_val && l15_transducer_returntype == RET_INV)
				inv_seen++;
			assert (transducer_l15_req_ack == l15_transducer_val)
				else other_error("acknowledge does not match the return valid");
		end
	end

	initial
	begin
		clk        = 1'b0;
		nrst       = 1'b0;
		stall      = 1'b0;
		pc_sel     = sel_seq;
		target     = '0;
		exp_pc     = RESET_VECTOR_DEFAULT;
		value_errs = 0;
		other_errs = 0;
		inv_seen   = 0;
		test_name  = "wake";
		repeat (5) @(posedge clk);
		#2;
		nrst = 1'b1;
		repeat (20)
		begin
			@(posedge clk);
			assert (!transducer_l15_val) else other_error("request raised before the wake-up");
		end
		wait_accept(40);
		assert (transducer_l15_address == RESET_VECTOR_DEFAULT)
			else value_error("boot address", RESET_VECTOR_DEFAULT, transducer_l15_address);
		test_name = "sequential";
		wait_deliveries(40);
		test_name = "redirect";
		redirect_in_flight(sel_target, 32'h4000_2a48);
		wait_deliveries(6);
		redirect_in_flight(sel_target, 32'h4001_0004);
		wait_deliveries(6);
		test_name = "stall";
		wait_accept(100);
		stall = 1'b1;
		wait_deliveries(1);  // fill in flight still lands
		repeat (15)
		begin
			@(posedge clk);
			assert (!transducer_l15_val) else other_error("request made while stalled");
		end
		#2;
		stall = 1'b0;
		wait_deliveries(4);
		test_name = "restart";
		redirect_in_flight(sel_reset, '0);
		wait_deliveries(6);
		test_name = "non-fill";
		assert (inv_seen > 0) else other_error("no invalidation return was seen");
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/l15_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module l15_mem_model #(
	parameter logic [31:0] PATTERN    = 32'h5ac3_96e1,
	parameter logic [31:0] SEED       = 32'h0000_0001,
	parameter int          WAKE_DELAY = 24
) (
	input  logic        clk,
	input  logic        nrst,
	input  logic        transducer_l15_val,
	input  logic [31:0] transducer_l15_address,
	input  logic        transducer_l15_req_ack,
	output logic        l15_transducer_header_ack,
	output logic        l15_transducer_ack,
	output logic        l15_transducer_val,
	output logic [3:0]  l15_transducer_returntype,
	output logic [63:0] l15_transducer_data_0,
	output logic [63:0] l15_transducer_data_1
);
	import fetch_pkg::*;

	logic [31:0] req_addr;
	logic        accepted;
	int          ack_gap;
	int          n;

	// each slot holds the pattern of its own address, big-endian
	function automatic logic [127:0] fill_line(input logic [31:0] addr);
		logic [31:0] base;
		base = {addr[31:4], 4'h0};
		// data_1 carries words 2 and 3, data_0 words 0 and 1
		return {(base | 32'h8) ^ PATTERN, (base | 32'hc) ^ PATTERN,
			base ^ PATTERN, (base | 32'h4) ^ PATTERN};
	endfunction

	// starts and ends 2 ns after an edge
	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	// hold the return until the front end takes it
	task automatic send_return(input logic [3:0] rtype, input logic [127:0] line);
		int wait_n;
		l15_transducer_val        = 1'b1;
		l15_transducer_returntype = rtype;
		{l15_transducer_data_1, l15_transducer_data_0} = line;
		wait_n = 0;
		@(posedge clk);
		while (!transducer_l15_req_ack && wait_n < 50)
		begin
			wait_n++;
			@(posedge clk);
		end
		#2;
		l15_transducer_val = 1'b0;
	endtask

	initial
	begin
		void'($urandom(SEED));
		l15_transducer_header_ack = 1'b0;
		l15_transducer_ack        = 1'b0;
		l15_transducer_val        = 1'b0;
		l15_transducer_returntype = RET_LOAD;
		l15_transducer_data_0     = '0;
		l15_transducer_data_1     = '0;
		n = 0;
		do
		begin
			@(posedge clk);
			n++;
		end
		while (!nrst && n < 100);
		#2;
		idle_cycles(WAKE_DELAY);
		send_return(RET_INT, '0);  // wake-up
		forever
		begin
			@(posedge clk);
			if (transducer_l15_val)
			begin
				#2;
				idle_cycles($urandom_range(0, 3));  // header delay
				ack_gap = $urandom_range(0, 2);
				l15_transducer_header_ack = 1'b1;
				l15_transducer_ack        = (ack_gap == 0);
				n = 0;
				@(posedge clk);
				while (!transducer_l15_val && n < 400)
				begin
					n++;
					@(posedge clk);
				end
				accepted = transducer_l15_val;
				req_addr = transducer_l15_address;
				#2;
				l15_transducer_header_ack = 1'b0;
				l15_transducer_ack        = 1'b0;
				if (accepted)
				begin
					if (ack_gap > 0)
					begin
						idle_cycles(ack_gap - 1);
						l15_transducer_ack = 1'b1;
						idle_cycles(1);
						l15_transducer_ack = 1'b0;
					end
					idle_cycles($urandom_range(0, 5));  // response 1 to 6 cycles out
					if ($urandom_range(0, 2) == 0)
						send_return(RET_INV, {$urandom, $urandom, $urandom, $urandom});
					send_return(RET_IFILL, fill_line(req_addr));
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/fetch_align.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_align (
	input  logic        clk,
	input  logic        nrst,
	input  logic [63:0] l15_transducer_data_0,
	input  logic [63:0] l15_transducer_data_1,
	input  logic [31:0] addr,
	input  logic        fill_done,
	input  logic        drop_fill,
	output logic [31:0] instr,
	output logic [31:0] instr_pc,
	output logic        instr_val
);
	import fetch_pkg::*;

	l15_line_u   line;
	logic [31:0] word_be;   // as it sits in the line
	logic [31:0] word_le;
	logic        deliver;

	always_comb
	begin
		line.half.data_1 = l15_transducer_data_1;
		line.half.data_0 = l15_transducer_data_0;
	end

	always_comb
	begin
		case (addr[3:2])
			2'b00: word_be = line.word.w0;
			2'b01: word_be = line.word.w1;
			2'b10: word_be = line.word.w2;
			default: word_be = line.word.w3;
		endcase
	end

	// L1.5 data is big-endian
	assign word_le = {word_be[7:0], word_be[15:8], word_be[23:16], word_be[31:24]};
	assign deliver = fill_done && !drop_fill;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			instr     <= NOP_INSTR;
			instr_val <= 1'b0;
		end
		else
		begin
			instr     <= deliver ? word_le : NOP_INSTR;  // nop when idle or stale
			instr_val <= deliver;
		end
	end

	always_ff @(posedge clk)
	begin
		if (deliver)
			instr_pc <= addr;
	end

	a_instr_known: assert property (
		@(posedge clk) disable iff (!nrst)
		instr_val |-> !$isunknown({instr, instr_pc})
	) else $error("valid instruction carries unknown bits");

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// boot address and the word fed to decode when idle
	localparam logic [31:0] RESET_VECTOR_DEFAULT = 32'h4000_0000;
	localparam logic [31:0] NOP_INSTR            = 32'h0000_0033;

	// request fields toward the L1.5
	localparam logic [4:0] RQ_IFILL     = 5'b10000;  // imiss
	localparam logic [2:0] RQ_SIZE_WORD = 3'b010;    // 4 bytes

	// L1.5 return types
	localparam logic [3:0] RET_LOAD   = 4'b0000;
	localparam logic [3:0] RET_IFILL  = 4'b0001;
	localparam logic [3:0] RET_INV    = 4'b0011;
	localparam logic [3:0] RET_ST_ACK = 4'b0100;
	localparam logic [3:0] RET_INT    = 4'b0111;  // also the wake-up
	localparam logic [3:0] RET_ERR    = 4'b1100;

	typedef enum logic [1:0] {
		s_req,
		s_wait_ack,
		s_resp
	} fetch_state_e;

	typedef enum logic [1:0] {
		sel_seq,
		sel_reset,
		sel_target
	} pc_sel_e;

	// response line, seen as the two bus halves or as four instruction words
	typedef union packed {
		struct packed {
			logic [63:0] data_1;
			logic [63:0] data_0;
		} half;
		struct packed {
			logic [31:0] w2;  // upper half of data_1
			logic [31:0] w3;
			logic [31:0] w0;  // upper half of data_0
			logic [31:0] w1;
		} word;
	} l15_line_u;

endpackage

`default_nettype wire

//--- hdl/frontend_stage.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_stage #(
	parameter logic [31:0] RESET_VECTOR = fetch_pkg::RESET_VECTOR_DEFAULT
) (
	input  logic               clk,
	input  logic               nrst,
	input  logic               stall,
	input  fetch_pkg::pc_sel_e pc_sel,
	input  logic [31:0]        target,

	// to decode
	output logic [31:0]        instr,
	output logic [31:0]        instr_pc,
	output logic               instr_val,

	// L1.5 request
	output logic               transducer_l15_val,
	output logic [4:0]         transducer_l15_rqtype,
	output logic [2:0]         transducer_l15_size,
	output logic [31:0]        transducer_l15_address,
	input  logic               l15_transducer_header_ack,
	input  logic               l15_transducer_ack,

	// L1.5 response
	input  logic               l15_transducer_val,
	input  logic [3:0]         l15_transducer_returntype,
	input  logic [63:0]        l15_transducer_data_0,
	input  logic [63:0]        l15_transducer_data_1,
	output logic               transducer_l15_req_ack
);
	import fetch_pkg::*;

	fetch_state_e state;
	logic [31:0]  fetch_pc;
	logic         redirect_pending;
	logic         req_accept;
	logic         fill_done;
	logic         drop_fill;

	pc_gen #(
		.RESET_VECTOR(RESET_VECTOR)
	) pc_gen_i (
		.clk              (clk),
		.nrst             (nrst),
		.pc_sel           (pc_sel),
		.target           (target),
		.state            (state),
		.req_accept       (req_accept),
		.fill_done        (fill_done),
		.drop_fill        (drop_fill),
		.fetch_pc         (fetch_pc),
		.redirect_pending (redirect_pending)
	);

	l15_fetch_ctrl l15_fetch_ctrl_i (
		.clk                       (clk),
		.nrst                      (nrst),
		.stall                     (stall),
		.fetch_pc                  (fetch_pc),
		.redirect_pending          (redirect_pending),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_returntype (l15_transducer_returntype),
		.state                     (state),
		.transducer_l15_val        (transducer_l15_val),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_req_ack    (transducer_l15_req_ack),
		.req_accept                (req_accept),
		.fill_done                 (fill_done),
		.drop_fill                 (drop_fill)
	);

	// address out of the controller is the latched one during a fill
	fetch_align fetch_align_i (
		.clk                   (clk),
		.nrst                  (nrst),
		.l15_transducer_data_0 (l15_transducer_data_0),
		.l15_transducer_data_1 (l15_transducer_data_1),
		.addr                  (transducer_l15_address),
		.fill_done             (fill_done),
		.drop_fill             (drop_fill),
		.instr                 (instr),
		.instr_pc              (instr_pc),
		.instr_val             (instr_val)
	);

endmodule

`default_nettype wire

//--- hdl/l15_fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module l15_fetch_ctrl (
	input  logic                    clk,
	input  logic                    nrst,
	input  logic                    stall,
	input  logic [31:0]             fetch_pc,
	input  logic                    redirect_pending,
	input  logic                    l15_transducer_header_ack,
	input  logic                    l15_transducer_ack,
	input  logic                    l15_transducer_val,
	input  logic [3:0]              l15_transducer_returntype,
	output fetch_pkg::fetch_state_e state,
	output logic                    transducer_l15_val,
	output logic [4:0]              transducer_l15_rqtype,
	output logic [2:0]              transducer_l15_size,
	output logic [31:0]             transducer_l15_address,
	output logic                    transducer_l15_req_ack,
	output logic                    req_accept,
	output logic                    fill_done,
	output logic                    drop_fill
);
	import fetch_pkg::*;

	fetch_state_e state_q;
	fetch_state_e state_d;
	logic         wake_up;
	logic         stale_q;    // a redirect came in during this fill
	logic [31:0]  addr_q;
	logic         int_ret;
	logic         fill_ret;

	assign int_ret  = l15_transducer_val && (l15_transducer_returntype == RET_INT);
	assign fill_ret = (l15_transducer_returntype == RET_IFILL) ||
		(l15_transducer_returntype == RET_LOAD);

	// wake-up interrupt from the cache, sticky once seen
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			wake_up <= 1'b0;
		else if (int_ret)
			wake_up <= 1'b1;
	end

	// request side
	assign transducer_l15_val     = wake_up && (state_q == s_req) && !stall;
	assign req_accept             = transducer_l15_val && l15_transducer_header_ack;
	assign transducer_l15_rqtype  = RQ_IFILL;
	assign transducer_l15_size    = RQ_SIZE_WORD;
	assign transducer_l15_address = (state_q == s_req) ? fetch_pc : addr_q;

	// response side
	assign fill_done = (state_q == s_resp) && l15_transducer_val && fill_ret;
	assign drop_fill = fill_done && (stale_q || redirect_pending);

	always_comb
	begin
		if (state_q == s_resp)
			transducer_l15_req_ack = l15_transducer_val;
		else
			transducer_l15_req_ack = l15_transducer_val && !fill_ret;  // inv, int and such
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			s_req:
			begin
				if (req_accept)
					state_d = l15_transducer_ack ? s_resp : s_wait_ack;
			end
			s_wait_ack:
			begin
				if (l15_transducer_ack)
					state_d = s_resp;
			end
			s_resp:
			begin
				if (fill_done)
					state_d = s_req;
			end
			default:
				state_d = s_req;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state_q <= s_req;
			stale_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			if (fill_done)
				stale_q <= 1'b0;
			else if (state_q != s_req && redirect_pending)
				stale_q <= 1'b1;
		end
	end

	// address frozen for the whole fill
	always_ff @(posedge clk)
	begin
		if (req_accept)
			addr_q <= fetch_pc;
	end

	assign state = state_q;

	// no request may follow a cycle without wake-up unless the interrupt just came
	a_no_req_asleep: assert property (
		@(posedge clk) disable iff (!nrst)
		(!wake_up && !int_ret) |=> !transducer_l15_val
	) else $error("request raised before wake-up");

	a_state_legal: assert property (
		@(posedge clk) disable iff (!nrst)
		state_q inside {s_req, s_wait_ack, s_resp}
	) else $error("fetch FSM in unused encoding");

endmodule

`default_nettype wire

//--- hdl/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
	parameter logic [31:0] RESET_VECTOR = fetch_pkg::RESET_VECTOR_DEFAULT
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  fetch_pkg::pc_sel_e      pc_sel,
	input  logic [31:0]             target,
	input  fetch_pkg::fetch_state_e state,
	input  logic                    req_accept,
	input  logic                    fill_done,
	input  logic                    drop_fill,
	output logic [31:0]             fetch_pc,
	output logic                    redirect_pending
);
	import fetch_pkg::*;

	logic [31:0] pc_q;       // pc of the request being made or in flight
	logic [31:0] save_q;     // redirect seen while a fill was out
	logic        pending_q;
	logic        redirect_req;
	logic [31:0] redirect_val;
	logic        in_req;

	assign redirect_req = (pc_sel == sel_target) || (pc_sel == sel_reset);
	assign redirect_val = (pc_sel == sel_reset) ? RESET_VECTOR : target;
	assign in_req       = (state == s_req);

	// before acceptance the redirect goes straight onto the bus
	assign fetch_pc = (in_req && redirect_req) ? redirect_val : pc_q;

	// includes a redirect arriving this cycle, so a fill ending now is dropped too
	assign redirect_pending = pending_q || (redirect_req && !in_req);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc_q      <= RESET_VECTOR;
			pending_q <= 1'b0;
		end
		else if (fill_done)
		begin
			pending_q <= 1'b0;
			if (!drop_fill)
				pc_q <= pc_q + 32'd4;  // next sequential word
			else if (redirect_req)
				pc_q <= redirect_val;  // latest redirect wins
			else
				pc_q <= save_q;
		end
		else if (redirect_req)
		begin
			if (in_req)
				pc_q <= redirect_val;
			else
				pending_q <= 1'b1;
		end
	end

	// target of a redirect that has to wait for the fill
	always_ff @(posedge clk)
	begin
		if (redirect_req && !in_req)
			save_q <= redirect_val;
	end

	// instruction fetch only ever asks for whole words
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!nrst)
		fetch_pc[1:0] == 2'b00
	) else $error("fetch pc not word aligned: %h", fetch_pc);

endmodule

`default_nettype wire

//--- src.f
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/l15_fetch_ctrl.sv
hdl/fetch_align.sv
hdl/frontend_stage.sv
bench/l15_mem_model.sv
bench/frontend_tb.sv
